// ==== source/sgd_ctrl_pkg.sv ====
// shared widths, register map and bundle types; imported by every stage of the sgd_ctrl block
package sgd_ctrl_pkg;

    ////////////////////
    // widths
    ////////////////////

    // dma byte address
    localparam int addr_w     = 64;
    // byte lengths, op counts, cycle counts
    localparam int len_w      = 32;
    localparam int reg_w      = 32;
    localparam int reg_idx_w  = 6;
    // one hbm data beat
    localparam int beat_w     = 512;
    localparam int beat_bytes = 64;
    localparam int beat_shift = $clog2(beat_bytes);
    // completed-operation counters in status
    localparam int ops_cnt_w  = 16;

    ////////////////////
    // host register map
    ////////////////////

    // bit 0 holds the soft reset
    localparam logic [reg_idx_w-1:0] reg_soft_reset = 6'd0;
    localparam logic [reg_idx_w-1:0] reg_rd_addr_lo = 6'd20;
    localparam logic [reg_idx_w-1:0] reg_rd_addr_hi = 6'd21;
    localparam logic [reg_idx_w-1:0] reg_wr_addr_lo = 6'd22;
    localparam logic [reg_idx_w-1:0] reg_wr_addr_hi = 6'd23;
    localparam logic [reg_idx_w-1:0] reg_rd_len     = 6'd24;
    localparam logic [reg_idx_w-1:0] reg_wr_len     = 6'd25;
    localparam logic [reg_idx_w-1:0] reg_ops        = 6'd26;
    // bit 0 read enable, bit 1 write enable
    localparam logic [reg_idx_w-1:0] reg_dir        = 6'd27;
    // write with bit 0 set launches a job
    localparam logic [reg_idx_w-1:0] reg_start      = 6'd28;

    ////////////////////
    // bundles
    ////////////////////

    typedef struct packed {
        logic                 en;
        logic [reg_idx_w-1:0] idx;
        logic [reg_w-1:0]     data;
    } reg_wr_t;

    typedef struct packed {
        logic [addr_w-1:0] rd_addr;
        logic [addr_w-1:0] wr_addr;
        logic [len_w-1:0]  rd_len;
        logic [len_w-1:0]  wr_len;
        logic [len_w-1:0]  ops;
        logic              rd_en;
        logic              wr_en;
    } job_t;

    typedef struct packed {
        logic [addr_w-1:0] address;
        logic [len_w-1:0]  length;
    } dma_cmd_t;

    typedef struct packed {
        logic [beat_w-1:0] data;
        logic              last;
    } dma_beat_t;

    typedef struct packed {
        logic                 busy;
        logic [ops_cnt_w-1:0] rd_ops_done;
        logic [ops_cnt_w-1:0] wr_ops_done;
        logic [len_w-1:0]     cycles;
    } ctrl_status_t;

endpackage

// ==== source/ctrl_reg_file.sv ====
// host control registers; decodes job parameters, the start strobe and the soft reset
module ctrl_reg_file (
    input  logic                  hbm_clk,
    input  logic                  hbm_rstn,
    input  sgd_ctrl_pkg::reg_wr_t host_wr,
    output sgd_ctrl_pkg::job_t    job,
    output logic                  start,
    output logic                  core_rstn
);
    import sgd_ctrl_pkg::*;

    logic soft_reset;
    logic start_wr;
    logic start_wr_q;

    ////////////////////
    // parameter words
    ////////////////////

    // only hbm_rstn clears these, soft reset must survive its own write
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            job        <= '0;
            soft_reset <= 1'b0;
        end else if (host_wr.en) begin
            case (host_wr.idx)
                reg_soft_reset: soft_reset <= host_wr.data[0];
                // 64-bit addresses built from lo/hi word pairs
                reg_rd_addr_lo: job.rd_addr[reg_w-1:0]      <= host_wr.data;
                reg_rd_addr_hi: job.rd_addr[addr_w-1:reg_w] <= host_wr.data;
                reg_wr_addr_lo: job.wr_addr[reg_w-1:0]      <= host_wr.data;
                reg_wr_addr_hi: job.wr_addr[addr_w-1:reg_w] <= host_wr.data;
                reg_rd_len:     job.rd_len                  <= host_wr.data;
                reg_wr_len:     job.wr_len                  <= host_wr.data;
                reg_ops:        job.ops                     <= host_wr.data;
                reg_dir: begin
                    job.rd_en <= host_wr.data[0];
                    job.wr_en <= host_wr.data[1];
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // start strobe
    ////////////////////

    // start write seen this cycle
    assign start_wr = host_wr.en && (host_wr.idx == reg_start) && host_wr.data[0];

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            start_wr_q <= 1'b0;
        end else begin
            start_wr_q <= start_wr;
        end
    end

    // back-to-back start writes give a single pulse
    assign start = start_wr && !start_wr_q;

    // core reset, registered once
    always_ff @(posedge hbm_clk) begin
        core_rstn <= hbm_rstn && !soft_reset;
    end

    a_start_pulse: assert property (
        @(posedge hbm_clk) disable iff (!hbm_rstn)
        start |=> !start
    );

endmodule

// ==== source/job_launch.sv ====
// job launch stage; snapshots parameters on start, tracks busy and times the job
module job_launch (
    input  logic                           hbm_clk,
    input  logic                           core_rstn,
    input  sgd_ctrl_pkg::job_t             job,
    input  logic                           start,
    input  logic                           job_ready,
    input  logic                           job_done,
    output sgd_ctrl_pkg::job_t             job_q,
    output logic                           job_valid,
    output logic                           busy,
    output logic [sgd_ctrl_pkg::len_w-1:0] cycles
);

    logic launch;

    // starts while a job runs are dropped
    assign launch = start && !busy;

    // parameter snapshot, held for the whole job
    always_ff @(posedge hbm_clk) begin
        if (launch) begin
            job_q <= job;
        end
    end

    ////////////////////
    // handshake and busy
    ////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!core_rstn) begin
            job_valid <= 1'b0;
            busy      <= 1'b0;
        end else if (launch) begin
            job_valid <= 1'b1;
            busy      <= 1'b1;
        end else begin
            // valid holds until the issue stage takes the job
            if (job_valid && job_ready) begin
                job_valid <= 1'b0;
            end
            if (job_done) begin
                busy <= 1'b0;
            end
        end
    end

    // elapsed busy cycles, left in place after the job ends
    always_ff @(posedge hbm_clk) begin
        if (!core_rstn) begin
            cycles <= '0;
        end else if (launch) begin
            cycles <= '0;
        end else if (busy) begin
            cycles <= cycles + 1'b1;
        end
    end

    a_done_while_busy: assert property (
        @(posedge hbm_clk) disable iff (!core_rstn)
        job_done |-> busy
    );

endmodule

// ==== source/dma_cmd_issue.sv ====
// dma command issue; one read and one write command per operation, counts ended operations
module dma_cmd_issue (
    input  logic                               hbm_clk,
    input  logic                               core_rstn,
    input  sgd_ctrl_pkg::job_t                 job_q,
    input  logic                               job_valid,
    input  logic                               rd_cmd_ready,
    input  logic                               wr_cmd_ready,
    input  logic                               rd_op_end,
    input  logic                               wr_op_end,
    output logic                               job_ready,
    output sgd_ctrl_pkg::dma_cmd_t             rd_cmd,
    output logic                               rd_cmd_valid,
    output sgd_ctrl_pkg::dma_cmd_t             wr_cmd,
    output logic                               wr_cmd_valid,
    output logic                               rd_go,
    output logic                               wr_go,
    output logic [sgd_ctrl_pkg::len_w-1:0]     rd_len_beats,
    output logic [sgd_ctrl_pkg::len_w-1:0]     wr_len_beats,
    output logic [sgd_ctrl_pkg::ops_cnt_w-1:0] rd_ops_done,
    output logic [sgd_ctrl_pkg::ops_cnt_w-1:0] wr_ops_done,
    output logic                               job_done
);
    import sgd_ctrl_pkg::*;

    // direction index 0 is read, 1 is write
    job_t                 job_r;
    logic                 active;
    logic                 accept;
    logic [1:0]           dir_en;
    logic [1:0]           cmd_ready;
    logic [1:0]           op_end;
    logic [1:0]           cmd_valid;
    logic [1:0]           inflight;
    logic [1:0]           dir_complete;
    logic [ops_cnt_w-1:0] ops_done [2];

    // byte length to beats, short lengths still move one beat
    function automatic logic [len_w-1:0] len_to_beats(input logic [len_w-1:0] len);
        logic [len_w-1:0] beats;
        beats = len >> beat_shift;
        return (beats == '0) ? len_w'(1) : beats;
    endfunction

    assign job_ready = !active;
    assign accept    = job_valid && job_ready;
    assign dir_en    = {job_r.wr_en, job_r.rd_en};
    assign cmd_ready = {wr_cmd_ready, rd_cmd_ready};
    assign op_end    = {wr_op_end, rd_op_end};

    // accepted job, stable while active
    always_ff @(posedge hbm_clk) begin
        if (accept) begin
            job_r <= job_q;
        end
    end

    ////////////////////
    // per-direction issue
    ////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!core_rstn) begin
            active    <= 1'b0;
            cmd_valid <= '0;
            inflight  <= '0;
            ops_done  <= '{default: '0};
        end else if (accept) begin
            active <= 1'b1;
            for (int d = 0; d < 2; d++) begin
                // op 0 goes out the cycle after acceptance
                cmd_valid[d] <= (d == 0 ? job_q.rd_en : job_q.wr_en) && (job_q.ops != '0);
                inflight[d]  <= 1'b0;
                ops_done[d]  <= '0;
            end
        end else begin
            if (job_done) begin
                active <= 1'b0;
            end
            for (int d = 0; d < 2; d++) begin
                if (cmd_valid[d] && cmd_ready[d]) begin
                    cmd_valid[d] <= 1'b0;
                    inflight[d]  <= 1'b1;
                end
                // next op issued only once this one has ended
                if (op_end[d]) begin
                    inflight[d]  <= 1'b0;
                    ops_done[d]  <= ops_done[d] + 1'b1;
                    cmd_valid[d] <= (len_w'(ops_done[d]) + len_w'(1)) < job_r.ops;
                end
            end
        end
    end

    // disabled direction counts as done
    always_comb begin
        for (int d = 0; d < 2; d++) begin
            dir_complete[d] = !dir_en[d] || (len_w'(ops_done[d]) == job_r.ops);
        end
    end

    assign job_done = active && (&dir_complete);

    ////////////////////
    // outputs
    ////////////////////

    assign rd_cmd       = '{address: job_r.rd_addr, length: job_r.rd_len};
    assign wr_cmd       = '{address: job_r.wr_addr, length: job_r.wr_len};
    assign rd_cmd_valid = cmd_valid[0];
    assign wr_cmd_valid = cmd_valid[1];
    // go fires on the command transfer itself
    assign rd_go        = cmd_valid[0] && rd_cmd_ready;
    assign wr_go        = cmd_valid[1] && wr_cmd_ready;
    assign rd_len_beats = len_to_beats(job_r.rd_len);
    assign wr_len_beats = len_to_beats(job_r.wr_len);
    assign rd_ops_done  = ops_done[0];
    assign wr_ops_done  = ops_done[1];

    // op end from the data stream only closes an issued op, so the next command waits for it
    a_one_op_in_flight: assert property (
        @(posedge hbm_clk) disable iff (!core_rstn)
        (op_end & ~inflight) == 2'b00
    );

endmodule

// ==== source/dma_data_stream.sv ====
// dma data path; emits counting write beats and sinks read beats per operation
module dma_data_stream (
    input  logic                            hbm_clk,
    input  logic                            core_rstn,
    input  logic                            rd_go,
    input  logic                            wr_go,
    input  logic [sgd_ctrl_pkg::len_w-1:0]  rd_len_beats,
    input  logic [sgd_ctrl_pkg::len_w-1:0]  wr_len_beats,
    input  logic                            wr_data_ready,
    input  logic                            rd_data_valid,
    input  logic [sgd_ctrl_pkg::beat_w-1:0] rd_data,
    output sgd_ctrl_pkg::dma_beat_t         wr_data,
    output logic                            wr_data_valid,
    output logic                            rd_data_ready,
    output logic                            rd_op_end,
    output logic                            wr_op_end
);
    import sgd_ctrl_pkg::*;

    // index 0 read side, 1 write side
    logic [1:0]       go;
    logic [1:0]       xfer;
    logic [1:0]       active;
    logic [1:0]       last;
    logic [len_w-1:0] beat      [2];
    logic [len_w-1:0] len_beats [2];

    assign go           = {wr_go, rd_go};
    assign len_beats[0] = rd_len_beats;
    assign len_beats[1] = wr_len_beats;
    assign xfer         = {wr_data_valid && wr_data_ready, rd_data_valid && rd_data_ready};

    // final beat of the operation
    always_comb begin
        for (int d = 0; d < 2; d++) begin
            last[d] = (beat[d] == len_beats[d] - 1'b1);
        end
    end

    ////////////////////
    // beat counters
    ////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!core_rstn) begin
            active <= '0;
            beat   <= '{default: '0};
        end else begin
            for (int d = 0; d < 2; d++) begin
                if (go[d]) begin
                    active[d] <= 1'b1;
                    beat[d]   <= '0;
                end else if (xfer[d]) begin
                    if (last[d]) begin
                        active[d] <= 1'b0;
                    end else begin
                        beat[d] <= beat[d] + 1'b1;
                    end
                end
            end
        end
    end

    // write pattern is the beat index
    assign wr_data       = '{data: beat_w'(beat[1]), last: last[1]};
    assign wr_data_valid = active[1];
    // read side takes beats whenever an op is open
    assign rd_data_ready = active[0];
    assign rd_op_end     = xfer[0] && last[0];
    assign wr_op_end     = xfer[1] && last[1];

    // stalled write beat stays put
    a_wr_hold: assert property (
        @(posedge hbm_clk) disable iff (!core_rstn)
        wr_data_valid && !wr_data_ready |=> wr_data_valid && $stable(wr_data)
    );

    // payload is not consumed but must be driven
    a_rd_known: assert property (
        @(posedge hbm_clk) disable iff (!core_rstn)
        xfer[0] |-> !$isunknown(rd_data)
    );

endmodule

// ==== source/sgd_ctrl_top.sv ====
// top of the sgd control block; chains register file, launch, command issue and data path
module sgd_ctrl_top (
    input  logic                            hbm_clk,
    input  logic                            hbm_rstn,
    input  sgd_ctrl_pkg::reg_wr_t           host_wr,
    input  logic                            rd_cmd_ready,
    input  logic                            wr_cmd_ready,
    input  logic                            wr_data_ready,
    input  logic                            rd_data_valid,
    input  logic [sgd_ctrl_pkg::beat_w-1:0] rd_data,
    output sgd_ctrl_pkg::dma_cmd_t          rd_cmd,
    output logic                            rd_cmd_valid,
    output sgd_ctrl_pkg::dma_cmd_t          wr_cmd,
    output logic                            wr_cmd_valid,
    output sgd_ctrl_pkg::dma_beat_t         wr_data,
    output logic                            wr_data_valid,
    output logic                            rd_data_ready,
    output sgd_ctrl_pkg::ctrl_status_t      status
);
    import sgd_ctrl_pkg::*;

    job_t                 job;
    job_t                 job_q;
    logic                 start;
    logic                 core_rstn;
    logic                 job_valid;
    logic                 job_ready;
    logic                 job_done;
    logic                 busy;
    logic [len_w-1:0]     cycles;
    logic                 rd_go;
    logic                 wr_go;
    logic [len_w-1:0]     rd_len_beats;
    logic [len_w-1:0]     wr_len_beats;
    logic                 rd_op_end;
    logic                 wr_op_end;
    logic [ops_cnt_w-1:0] rd_ops_done;
    logic [ops_cnt_w-1:0] wr_ops_done;

    ////////////////////
    // control path
    ////////////////////

    ctrl_reg_file u_reg_file (
        .hbm_clk   (hbm_clk),
        .hbm_rstn  (hbm_rstn),
        .host_wr   (host_wr),
        .job       (job),
        .start     (start),
        .core_rstn (core_rstn)
    );

    job_launch u_launch (
        .hbm_clk   (hbm_clk),
        .core_rstn (core_rstn),
        .job       (job),
        .start     (start),
        .job_ready (job_ready),
        .job_done  (job_done),
        .job_q     (job_q),
        .job_valid (job_valid),
        .busy      (busy),
        .cycles    (cycles)
    );

    ////////////////////
    // dma side
    ////////////////////

    dma_cmd_issue u_cmd_issue (
        .hbm_clk      (hbm_clk),
        .core_rstn    (core_rstn),
        .job_q        (job_q),
        .job_valid    (job_valid),
        .rd_cmd_ready (rd_cmd_ready),
        .wr_cmd_ready (wr_cmd_ready),
        .rd_op_end    (rd_op_end),
        .wr_op_end    (wr_op_end),
        .job_ready    (job_ready),
        .rd_cmd       (rd_cmd),
        .rd_cmd_valid (rd_cmd_valid),
        .wr_cmd       (wr_cmd),
        .wr_cmd_valid (wr_cmd_valid),
        .rd_go        (rd_go),
        .wr_go        (wr_go),
        .rd_len_beats (rd_len_beats),
        .wr_len_beats (wr_len_beats),
        .rd_ops_done  (rd_ops_done),
        .wr_ops_done  (wr_ops_done),
        .job_done     (job_done)
    );

    dma_data_stream u_data_stream (
        .hbm_clk       (hbm_clk),
        .core_rstn     (core_rstn),
        .rd_go         (rd_go),
        .wr_go         (wr_go),
        .rd_len_beats  (rd_len_beats),
        .wr_len_beats  (wr_len_beats),
        .wr_data_ready (wr_data_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .wr_data       (wr_data),
        .wr_data_valid (wr_data_valid),
        .rd_data_ready (rd_data_ready),
        .rd_op_end     (rd_op_end),
        .wr_op_end     (wr_op_end)
    );

    // status word for the host
    assign status = '{busy: busy, rd_ops_done: rd_ops_done,
                      wr_ops_done: wr_ops_done, cycles: cycles};

endmodule

// ==== tests/sgd_ctrl_tb.sv ====
// self-checking testbench for sgd_ctrl_top; runs a job table and checks commands, beats, status
module sgd_ctrl_tb;
    import sgd_ctrl_pkg::*;

    // one job: stimulus columns, then expected status counts
    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [63:0] rd_addr;
        logic [63:0] wr_addr;
        logic [31:0] rd_len;
        logic [31:0] wr_len;
        logic [31:0] ops;
        logic [6:0]  stall_pct;
        logic        double_start;
        logic        soft_reset;
        logic [15:0] exp_rd_ops;
        logic [15:0] exp_wr_ops;
    } job_row_t;

    logic              hbm_clk;
    logic              hbm_rstn;
    reg_wr_t           host_wr;
    logic              rd_cmd_ready;
    logic              wr_cmd_ready;
    logic              wr_data_ready;
    logic              rd_data_valid;
    logic [beat_w-1:0] rd_data;
    dma_cmd_t          rd_cmd;
    logic              rd_cmd_valid;
    dma_cmd_t          wr_cmd;
    logic              wr_cmd_valid;
    dma_beat_t         wr_data;
    logic              wr_data_valid;
    logic              rd_data_ready;
    ctrl_status_t      status;

    job_row_t  jobs [$];
    string     job_names [$];
    // monitor captures for the running job
    dma_cmd_t  rd_cmds [$];
    dma_cmd_t  wr_cmds [$];
    dma_beat_t wr_beats [$];
    int        rd_beat_cnt;
    integer    seed = 61874;
    int        stall_pct;
    string     test_name;
    int        test_errors;
    int        total_errors;
    int        tests_run;
    int        tests_failed;
    int        check_count;
    int        watchdog_cycles;
    bit        table_loaded;
    bit        hold_check_en;
    logic      rd_xfer_q;
    // last cycle's handshake state, for hold checks
    logic      prev_rd_cmd_valid;
    logic      prev_rd_cmd_ready;
    dma_cmd_t  prev_rd_cmd;
    logic      prev_wr_cmd_valid;
    logic      prev_wr_cmd_ready;
    dma_cmd_t  prev_wr_cmd;
    logic      prev_wr_data_valid;
    logic      prev_wr_data_ready;
    dma_beat_t prev_wr_data;

    sgd_ctrl_top u_dut (
        .hbm_clk       (hbm_clk),
        .hbm_rstn      (hbm_rstn),
        .host_wr       (host_wr),
        .rd_cmd_ready  (rd_cmd_ready),
        .wr_cmd_ready  (wr_cmd_ready),
        .wr_data_ready (wr_data_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .rd_cmd        (rd_cmd),
        .rd_cmd_valid  (rd_cmd_valid),
        .wr_cmd        (wr_cmd),
        .wr_cmd_valid  (wr_cmd_valid),
        .wr_data       (wr_data),
        .wr_data_valid (wr_data_valid),
        .rd_data_ready (rd_data_ready),
        .status        (status)
    );

    initial begin
        hbm_clk = 1'b0;
        forever #50 hbm_clk = ~hbm_clk;
    end

    ////////////////////
    // model and checks
    ////////////////////

    // beats per op, short lengths still move one beat
    function automatic int beats_of(input logic [31:0] len);
        int n;
        n = int'(len >> beat_shift);
        return (n == 0) ? 1 : n;
    endfunction

    // high with probability 100 - stall_pct
    function automatic logic ready_roll();
        return ($unsigned($random(seed)) % 100) >= stall_pct;
    endfunction

    task automatic check_eq(input string what, input logic [beat_w:0] exp_v,
                            input logic [beat_w:0] act_v);
        check_count++;
        assert (act_v === exp_v) else begin
            $display("Fail %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count++;
        assert (cond === 1'b1) else begin
            $display("%s: %s", test_name, what);
            test_errors++;
        end
    endtask

    task automatic add_job(input string name, input logic rd_en, input logic wr_en,
                           input logic [63:0] rd_addr, input logic [63:0] wr_addr,
                           input int rd_len, input int wr_len, input int ops, input int stall,
                           input logic dbl, input logic srst, input int exp_rd, input int exp_wr);
        job_row_t row;
        row = '{rd_en, wr_en, rd_addr, wr_addr, rd_len, wr_len, ops, 7'(stall),
                dbl, srst, 16'(exp_rd), 16'(exp_wr)};
        jobs.push_back(row);
        job_names.push_back(name);
        // per op: beats both ways plus one for the op itself
        watchdog_cycles += 20 * ops * (beats_of(rd_len) + beats_of(wr_len) + 1);
    endtask

    task automatic load_jobs();
        watchdog_cycles = 2000;
        add_job("wr_only", 1'b0, 1'b1, 64'h0, 64'h1_0000_1000, 0, 256, 3, 0, 1'b0, 1'b0, 0, 3);
        add_job("rd_only", 1'b1, 1'b0, 64'h2_0004_0000, 64'h0, 128, 0, 2, 40, 1'b0, 1'b0, 2, 0);
        add_job("both_stall", 1'b1, 1'b1, 64'h3_0000_0040, 64'h4_0000_0080,
                192, 320, 3, 50, 1'b0, 1'b0, 3, 3);
        add_job("double_start", 1'b1, 1'b1, 64'h10_0000, 64'h20_0000,
                256, 128, 2, 20, 1'b1, 1'b0, 2, 2);
        // counts expected back at zero after the soft reset
        add_job("soft_reset", 1'b1, 1'b1, 64'h30_0000, 64'h40_0000,
                512, 512, 4, 30, 1'b0, 1'b1, 0, 0);
        add_job("after_reset", 1'b1, 1'b1, 64'hff_ffff_ffc0, 64'h50_0000,
                100, 32, 2, 10, 1'b0, 1'b0, 2, 2);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    ////////////////////
    // host side
    ////////////////////

    // one write cycle, then the bus goes idle
    task automatic reg_write(input logic [reg_idx_w-1:0] idx, input logic [reg_w-1:0] data);
        @(negedge hbm_clk);
        host_wr = '{en: 1'b1, idx: idx, data: data};
        @(negedge hbm_clk);
        host_wr = '0;
    endtask

    task automatic program_job(input job_row_t row);
        reg_write(reg_rd_addr_lo, row.rd_addr[31:0]);
        reg_write(reg_rd_addr_hi, row.rd_addr[63:32]);
        reg_write(reg_wr_addr_lo, row.wr_addr[31:0]);
        reg_write(reg_wr_addr_hi, row.wr_addr[63:32]);
        reg_write(reg_rd_len, row.rd_len);
        reg_write(reg_wr_len, row.wr_len);
        reg_write(reg_ops, row.ops);
        reg_write(reg_dir, {30'b0, row.wr_en, row.rd_en});
    endtask

    // all valids, rd_data_ready and status cleared
    task automatic check_idle(input job_row_t row);
        check_eq("valid outputs", 4'b0000,
                 {rd_cmd_valid, wr_cmd_valid, wr_data_valid, rd_data_ready});
        check_eq("busy", 1'b0, status.busy);
        check_eq("read ops done", row.exp_rd_ops, status.rd_ops_done);
        check_eq("write ops done", row.exp_wr_ops, status.wr_ops_done);
        check_eq("cycles", 0, status.cycles);
    endtask

    task automatic apply_soft_reset(input job_row_t row);
        // let the job get going first
        while (wr_beats.size() < 2) @(negedge hbm_clk);
        hold_check_en = 1'b0;
        reg_write(reg_soft_reset, 32'h1);
        repeat (3) @(negedge hbm_clk);
        check_idle(row);
        reg_write(reg_soft_reset, 32'h0);
        repeat (3) @(negedge hbm_clk);
        hold_check_en = 1'b1;
    endtask

    task automatic check_job(input job_row_t row);
        int n_rd;
        int n_wr;
        int exp_rd_cmds;
        int exp_wr_cmds;
        int min_cycles;
        n_rd        = beats_of(row.rd_len);
        n_wr        = beats_of(row.wr_len);
        exp_rd_cmds = row.rd_en ? int'(row.ops) : 0;
        exp_wr_cmds = row.wr_en ? int'(row.ops) : 0;
        min_cycles  = (exp_rd_cmds * n_rd > exp_wr_cmds * n_wr) ?
                      exp_rd_cmds * n_rd : exp_wr_cmds * n_wr;
        // nothing left running once the job is over
        check_eq("valid outputs", 4'b0000,
                 {rd_cmd_valid, wr_cmd_valid, wr_data_valid, rd_data_ready});
        check_eq("read command count", exp_rd_cmds, rd_cmds.size());
        foreach (rd_cmds[k]) begin
            check_eq("read command", {row.rd_addr, row.rd_len}, rd_cmds[k]);
        end
        check_eq("write command count", exp_wr_cmds, wr_cmds.size());
        foreach (wr_cmds[k]) begin
            check_eq("write command", {row.wr_addr, row.wr_len}, wr_cmds[k]);
        end
        // beat index within the op, last on the final one
        check_eq("write beat count", exp_wr_cmds * n_wr, wr_beats.size());
        foreach (wr_beats[k]) begin
            check_eq("write beat", {beat_w'(k % n_wr), (k % n_wr) == (n_wr - 1)}, wr_beats[k]);
        end
        check_eq("read beat count", exp_rd_cmds * n_rd, rd_beat_cnt);
        check_eq("read ops done", row.exp_rd_ops, status.rd_ops_done);
        check_eq("write ops done", row.exp_wr_ops, status.wr_ops_done);
        check_true(int'(status.cycles) >= min_cycles, "cycle count is below the beat count");
    endtask

    task automatic run_job(input int i);
        job_row_t row;
        row = jobs[i];
        start_test(job_names[i]);
        stall_pct = int'(row.stall_pct);
        rd_cmds.delete();
        wr_cmds.delete();
        wr_beats.delete();
        rd_beat_cnt = 0;
        program_job(row);
        reg_write(reg_start, 32'h1);
        if (row.double_start) begin
            // second start lands while the first job runs
            check_true(status.busy, "job not busy before the second start");
            reg_write(reg_start, 32'h1);
        end
        if (row.soft_reset) begin
            apply_soft_reset(row);
        end else begin
            while (!status.busy) @(negedge hbm_clk);
            while (status.busy) @(negedge hbm_clk);
            // quiet period, a stray relaunch would issue commands here
            repeat (4) @(negedge hbm_clk);
            check_job(row);
        end
        finish_test();
    endtask

    ////////////////////
    // dma environment
    ////////////////////

    // random readies, read valid held until its transfer
    always @(negedge hbm_clk) begin
        if (hbm_rstn) begin
            rd_cmd_ready  = ready_roll();
            wr_cmd_ready  = ready_roll();
            wr_data_ready = ready_roll();
            if (!rd_data_valid || rd_xfer_q) begin
                rd_data_valid = ready_roll();
                rd_data       = {16{rd_beat_cnt}};
            end
        end
    end

    // transfers seen at the clock edge
    always @(posedge hbm_clk) begin
        if (hbm_rstn) begin
            if (rd_cmd_valid && rd_cmd_ready) begin
                rd_cmds.push_back(rd_cmd);
            end
            if (wr_cmd_valid && wr_cmd_ready) begin
                wr_cmds.push_back(wr_cmd);
            end
            if (wr_data_valid && wr_data_ready) begin
                wr_beats.push_back(wr_data);
            end
            rd_xfer_q = rd_data_valid && rd_data_ready;
            if (rd_xfer_q) begin
                rd_beat_cnt++;
            end
            // a stalled valid keeps itself and its payload
            if (hold_check_en) begin
                if (prev_rd_cmd_valid && !prev_rd_cmd_ready) begin
                    check_true(rd_cmd_valid && rd_cmd == prev_rd_cmd,
                               "read command dropped or changed before its transfer");
                end
                if (prev_wr_cmd_valid && !prev_wr_cmd_ready) begin
                    check_true(wr_cmd_valid && wr_cmd == prev_wr_cmd,
                               "write command dropped or changed before its transfer");
                end
                if (prev_wr_data_valid && !prev_wr_data_ready) begin
                    check_true(wr_data_valid && wr_data == prev_wr_data,
                               "write beat dropped or changed before its transfer");
                end
            end
        end
        prev_rd_cmd_valid  = rd_cmd_valid;
        prev_rd_cmd_ready  = rd_cmd_ready;
        prev_rd_cmd        = rd_cmd;
        prev_wr_cmd_valid  = wr_cmd_valid;
        prev_wr_cmd_ready  = wr_cmd_ready;
        prev_wr_cmd        = wr_cmd;
        prev_wr_data_valid = wr_data_valid;
        prev_wr_data_ready = wr_data_ready;
        prev_wr_data       = wr_data;
    end

    ////////////////////
    // run control
    ////////////////////

    initial begin
        wait (table_loaded);
        repeat (watchdog_cycles) @(posedge hbm_clk);
        $display("watchdog expired after %0d cycles, a job never finished", watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        job_row_t zero_row;
        zero_row      = '0;
        host_wr       = '0;
        rd_cmd_ready  = 1'b0;
        wr_cmd_ready  = 1'b0;
        wr_data_ready = 1'b0;
        rd_data_valid = 1'b0;
        rd_data       = '0;
        rd_xfer_q     = 1'b0;
        hold_check_en = 1'b0;
        stall_pct     = 0;
        hbm_rstn      = 1'b0;
        load_jobs();
        table_loaded = 1'b1;
        repeat (16) @(negedge hbm_clk);
        hbm_rstn = 1'b1;
        // core reset trails hbm_rstn by one register
        start_test("reset");
        repeat (3) @(negedge hbm_clk);
        check_idle(zero_row);
        finish_test();
        hold_check_en = 1'b1;
        foreach (jobs[i]) begin
            run_job(i);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sgd_ctrl.f ====
source/sgd_ctrl_pkg.sv
source/ctrl_reg_file.sv
source/job_launch.sv
source/dma_cmd_issue.sv
source/dma_data_stream.sv
source/sgd_ctrl_top.sv
tests/sgd_ctrl_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := sgd_ctrl_tb
FILELIST  := sgd_ctrl.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
